// File: icache.f
icache_pkg.sv
icache_array.sv
icache_mem_port.sv
icache_ctrl.sv
icache_top.sv
tb_mem_responder.sv
tb_icache_top.sv

// File: icache_array.sv
`timescale 1ns/10ps
`default_nettype none

module icache_array import icache_pkg::*; #(
    parameter int SETS = 64
) (
    input  wire logic   clk,
    input  wire logic   rstn,
    input  wire logic   rd_en,
    input  wire addr_t  rd_addr,
    input  wire logic   wr_en,
    input  wire logic   inv_en,
    input  wire addr_t  wr_addr,
    input  wire block_t fill_block,
    output logic        hit,
    output word_t       rd_word
);

    localparam int IDX_W  = $clog2(SETS);
    localparam int TAG_W  = 32 - OFFSET_W - IDX_W;
    localparam int WSEL_W = $clog2(LINE_WORDS);

    typedef logic [IDX_W-1:0]  idx_t;
    typedef logic [TAG_W-1:0]  tag_t;
    typedef logic [WSEL_W-1:0] wsel_t;

    tag_t            tag_mem  [SETS];
    block_t          line_mem [SETS];
    logic [SETS-1:0] valid_q;

    idx_t   rd_idx, wr_idx;
    tag_t   rd_tag, wr_tag;
    wsel_t  rd_wsel;
    logic   fwd;
    block_t rd_line;

    // registered read side
    logic   set_valid_q;
    tag_t   set_tag_q;
    tag_t   addr_tag_q;

    assign rd_idx  = rd_addr[OFFSET_W +: IDX_W];
    assign rd_tag  = rd_addr[31 -: TAG_W];
    assign rd_wsel = rd_addr[2 +: WSEL_W];
    assign wr_idx  = wr_addr[OFFSET_W +: IDX_W];
    assign wr_tag  = wr_addr[31 -: TAG_W];

    // replay read lands on the same edge as the refill write
    assign fwd     = wr_en && (wr_idx == rd_idx);
    assign rd_line = fwd ? fill_block : line_mem[rd_idx];

    // tag and line storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_idx]  <= wr_tag;
            line_mem[wr_idx] <= fill_block;
        end
    end

    // valid bits
    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_idx] <= 1'b1;
        end else if (inv_en) begin
            valid_q[wr_idx] <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            set_valid_q <= 1'b0;
        end else if (rd_en) begin
            set_valid_q <= fwd | valid_q[rd_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            set_tag_q  <= fwd ? wr_tag : tag_mem[rd_idx];
            addr_tag_q <= rd_tag;
            rd_word    <= rd_line[rd_wsel*32 +: 32];
        end
    end

    // compare against the registered address tag
    assign hit = set_valid_q && (set_tag_q == addr_tag_q);

    // refill and invalidate share one write cycle
    a_wr_inv_excl: assert property (@(posedge clk) disable iff (!rstn)
        !(wr_en && inv_en));

endmodule

`default_nettype wire

// File: icache_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module icache_ctrl import icache_pkg::*; (
    input  wire logic       clk,
    input  wire logic       rstn,
    input  wire icache_op_e req_op,
    input  wire addr_t      req_addr,
    input  wire logic       req_cached,
    input  wire logic       stall,
    input  wire logic       hit,
    input  wire word_t      rd_word,
    input  wire logic       fill_done,
    input  wire word_t      fill_word,
    output word_t           ins,
    output logic            ins_valid,
    output logic            busy,
    output logic            rd_en,
    output addr_t           rd_addr,
    output logic            wr_en,
    output logic            inv_en,
    output addr_t           wr_addr,
    output logic            fill_start,
    output mem_req_t        fill_req
);

    icache_state_e state, state_nx;
    icache_op_e    op_q;
    addr_t         addr_q;
    word_t         word_q;
    logic          accept;
    logic          done;

    // answer ready in this cycle
    assign done = ((state == S_LOOKUP) && hit) || (state == S_WORD_DONE);
    assign ins_valid = done;

    // free only when idle or an answer is being handed over
    assign busy = !((state == S_IDLE) || (done && !stall));
    assign accept = !busy && (req_op != OP_NONE);

    always_comb begin
        state_nx = state;
        case (state)
            S_IDLE, S_WORD_DONE: begin
                if (!busy) begin
                    state_nx = S_IDLE;
                end
            end
            S_LOOKUP: begin
                // miss goes out for the line, hit behaves as a done state
                if (!hit) begin
                    state_nx = S_REQ_BLOCK;
                end else if (!stall) begin
                    state_nx = S_IDLE;
                end
            end
            S_REQ_BLOCK: state_nx = S_BLOCK_WAIT;
            S_BLOCK_WAIT: begin
                if (fill_done) begin
                    state_nx = S_REFILL;
                end
            end
            S_REFILL: begin
                // refill replays the lookup, invalidate just finishes
                state_nx = (op_q == OP_INDEX_INV) ? S_IDLE : S_LOOKUP;
            end
            S_REQ_WORD: state_nx = S_WORD_WAIT;
            S_WORD_WAIT: begin
                if (fill_done) begin
                    state_nx = S_WORD_DONE;
                end
            end
            default: state_nx = S_IDLE;
        endcase
        // a new request overrides the hand-over target
        if (accept) begin
            if (req_op == OP_INDEX_INV) begin
                state_nx = S_REFILL;
            end else if (req_cached) begin
                state_nx = S_LOOKUP;
            end else begin
                state_nx = S_REQ_WORD;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= S_IDLE;
            op_q  <= OP_NONE;
        end else begin
            state <= state_nx;
            if (accept) begin
                op_q <= req_op;
            end
        end
    end

    // request address and uncached word
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= req_addr;
        end
        if ((state == S_WORD_WAIT) && fill_done) begin
            word_q <= fill_word;
        end
    end

    assign ins = (state == S_WORD_DONE) ? word_q : rd_word;

    // read starts on acceptance, so the result is there in S_LOOKUP
    assign rd_en = (accept && (req_op == OP_FETCH) && req_cached)
                   || ((state == S_REFILL) && (op_q == OP_FETCH));
    assign rd_addr = (state == S_REFILL) ? addr_q : req_addr;

    assign wr_en   = (state == S_REFILL) && (op_q == OP_FETCH);
    assign inv_en  = (state == S_REFILL) && (op_q == OP_INDEX_INV);
    assign wr_addr = addr_q;

    // word address in both cases; the port aligns block requests
    assign fill_start     = (state == S_REQ_BLOCK) || (state == S_REQ_WORD);
    assign fill_req.block = (state == S_REQ_BLOCK);
    assign fill_req.addr  = {addr_q[31:2], 2'b00};

    // stalled answer stays put on the next cycle
    a_stall_hold: assert property (@(posedge clk) disable iff (!rstn)
        (ins_valid && stall) |=> (ins_valid && $stable(ins)));

    // request pulse lasts one cycle and serves only a fetch
    a_fill_pulse: assert property (@(posedge clk) disable iff (!rstn)
        fill_start |-> ((op_q == OP_FETCH) && !$past(fill_start)));

endmodule

`default_nettype wire

// File: icache_mem_port.sv
`timescale 1ns/10ps
`default_nettype none

module icache_mem_port import icache_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rstn,
    input  wire logic     fill_start,
    input  wire mem_req_t fill_req,
    input  wire logic     mem_req_ready,
    input  wire logic     mem_done,
    input  wire block_t   mem_rdata,
    output logic          mem_req_valid,
    output mem_req_t      mem_req,
    output logic          fill_done,
    output block_t        fill_block,
    output word_t         fill_word
);

    mem_req_t req_q;
    logic     wait_q;
    logic     [2:0] wsel;

    // request pending, then waiting for the answer
    always_ff @(posedge clk) begin
        if (!rstn) begin
            mem_req_valid <= 1'b0;
            wait_q        <= 1'b0;
            fill_done     <= 1'b0;
        end else begin
            fill_done <= wait_q && mem_done;
            if (fill_start) begin
                mem_req_valid <= 1'b1;
            end else if (mem_req_valid && mem_req_ready) begin
                mem_req_valid <= 1'b0;
                wait_q        <= 1'b1;
            end else if (wait_q && mem_done) begin
                wait_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_start) begin
            req_q <= fill_req;
        end
        if (wait_q && mem_done) begin
            fill_block <= mem_rdata;
        end
    end

    // line-aligned on the bus for a refill
    assign mem_req.block = req_q.block;
    assign mem_req.addr  = req_q.block ? {req_q.addr[31:OFFSET_W], {OFFSET_W{1'b0}}}
                                       : req_q.addr;

    // uncached word sits in lane 0
    assign wsel      = req_q.block ? req_q.addr[4:2] : 3'd0;
    assign fill_word = fill_block[wsel*32 +: 32];

    a_req_stable: assert property (@(posedge clk) disable iff (!rstn)
        (mem_req_valid && !mem_req_ready) |=> (mem_req_valid && $stable(mem_req)));

    // controller waits for fill_done before the next request
    a_no_overlap: assert property (@(posedge clk) disable iff (!rstn)
        fill_start |-> !(mem_req_valid || wait_q || fill_done));

endmodule

`default_nettype wire

// File: icache_pkg.sv
`default_nettype none

package icache_pkg;

    // one instruction
    typedef logic [31:0] word_t;

    // physical byte address
    typedef logic [31:0] addr_t;

    // line geometry
    localparam int LINE_WORDS = 8;
    localparam int OFFSET_W = 5;

    // full line, word 0 in the low lane
    typedef logic [LINE_WORDS*32-1:0] block_t;

    // cpu request codes
    typedef enum logic [1:0] {
        OP_NONE      = 2'd0,
        OP_FETCH     = 2'd1,
        OP_INDEX_INV = 2'd2
    } icache_op_e;

    // controller states
    // S_REFILL is the single array-write cycle, refill or invalidate
    typedef enum logic [2:0] {
        S_IDLE       = 3'd0,
        S_LOOKUP     = 3'd1,
        S_REQ_BLOCK  = 3'd2,
        S_BLOCK_WAIT = 3'd3,
        S_REFILL     = 3'd4,
        S_REQ_WORD   = 3'd5,
        S_WORD_WAIT  = 3'd6,
        S_WORD_DONE  = 3'd7
    } icache_state_e;

    // memory request, 33 bits
    typedef struct packed {
        // high for line refill, low for single uncached word
        logic  block;
        addr_t addr;
    } mem_req_t;

endpackage

`default_nettype wire

// File: icache_top.sv
`timescale 1ns/10ps
`default_nettype none

module icache_top import icache_pkg::*; #(
    parameter int SETS = 64
) (
    input  wire logic       clk,
    input  wire logic       rstn,
    input  wire icache_op_e req_op,
    input  wire addr_t      req_addr,
    input  wire logic       req_cached,
    input  wire logic       stall,
    input  wire logic       mem_req_ready,
    input  wire logic       mem_done,
    input  wire block_t     mem_rdata,
    output word_t           ins,
    output logic            ins_valid,
    output logic            busy,
    output logic            mem_req_valid,
    output mem_req_t        mem_req
);

    // controller to array
    logic     hit;
    word_t    rd_word;
    logic     rd_en;
    addr_t    rd_addr;
    logic     wr_en;
    logic     inv_en;
    addr_t    wr_addr;

    // controller to memory port
    logic     fill_start;
    mem_req_t fill_req;
    logic     fill_done;
    block_t   fill_block;
    word_t    fill_word;

    icache_ctrl i_icache_ctrl (
        .clk        (clk),
        .rstn       (rstn),
        .req_op     (req_op),
        .req_addr   (req_addr),
        .req_cached (req_cached),
        .stall      (stall),
        .hit        (hit),
        .rd_word    (rd_word),
        .fill_done  (fill_done),
        .fill_word  (fill_word),
        .ins        (ins),
        .ins_valid  (ins_valid),
        .busy       (busy),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .wr_en      (wr_en),
        .inv_en     (inv_en),
        .wr_addr    (wr_addr),
        .fill_start (fill_start),
        .fill_req   (fill_req)
    );

    icache_array #(
        .SETS (SETS)
    ) i_icache_array (
        .clk        (clk),
        .rstn       (rstn),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .wr_en      (wr_en),
        .inv_en     (inv_en),
        .wr_addr    (wr_addr),
        .fill_block (fill_block),
        .hit        (hit),
        .rd_word    (rd_word)
    );

    icache_mem_port i_icache_mem_port (
        .clk           (clk),
        .rstn          (rstn),
        .fill_start    (fill_start),
        .fill_req      (fill_req),
        .mem_req_ready (mem_req_ready),
        .mem_done      (mem_done),
        .mem_rdata     (mem_rdata),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .fill_done     (fill_done),
        .fill_block    (fill_block),
        .fill_word     (fill_word)
    );

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# build and run the icache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -j 0 -f icache.f --top-module tb_icache_top -o sim_icache
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/sim_icache 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TEST RESULT: PASS"; then
    exit 0
fi
exit 1

// File: tb_icache_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_icache_top import icache_pkg::*; ();

    localparam int SEED_INIT = 52387;
    localparam int N_TRANS   = 300;
    localparam int SETS      = 64;

    logic       clk;
    logic       rstn;
    icache_op_e req_op;
    addr_t      req_addr;
    logic       req_cached;
    logic       stall;
    logic       mem_req_ready;
    logic       mem_done;
    block_t     mem_rdata;
    word_t      ins;
    logic       ins_valid;
    logic       busy;
    logic       mem_req_valid;
    mem_req_t   mem_req;
    int         req_count;
    mem_req_t   last_req;

    int         seed;

    // reference model, valid and tag per set
    logic        model_valid [SETS];
    logic [20:0] model_tag   [SETS];

    // few tags over few sets gives hits, conflicts and misses
    logic [20:0] tag_pool [3] = '{21'h00123, 21'h1f0aa, 21'h00001};
    logic [5:0]  set_pool [4] = '{6'd5, 6'd6, 6'd40, 6'd63};

    icache_top #(
        .SETS (SETS)
    ) i_icache_top (
        .clk           (clk),
        .rstn          (rstn),
        .req_op        (req_op),
        .req_addr      (req_addr),
        .req_cached    (req_cached),
        .stall         (stall),
        .mem_req_ready (mem_req_ready),
        .mem_done      (mem_done),
        .mem_rdata     (mem_rdata),
        .ins           (ins),
        .ins_valid     (ins_valid),
        .busy          (busy),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req)
    );

    tb_mem_responder #(
        .SEED (SEED_INIT)
    ) i_mem (
        .clk           (clk),
        .rstn          (rstn),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .mem_done      (mem_done),
        .mem_rdata     (mem_rdata),
        .req_count     (req_count),
        .last_req      (last_req)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // expected instruction at a byte address
    function automatic word_t expected_word(addr_t byte_addr);
        return ((byte_addr >> 2) * 32'h9e37_79b1) ^ 32'ha5c3_3c5a;
    endfunction

    function automatic int rand_below(int n);
        int r;
        r = $random(seed);
        r = r & 32'h7fff_ffff;
        return r % n;
    endfunction

    function automatic addr_t random_addr();
        logic [20:0] tag;
        logic [5:0]  set;
        logic [2:0]  woff;
        tag  = tag_pool[rand_below(3)];
        set  = set_pool[rand_below(4)];
        woff = 3'(rand_below(8));
        return {tag, set, woff, 2'b00};
    endfunction

    task automatic report_fail(string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic expect_word(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp) else begin
            report_fail($sformatf("ERROR: %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic expect_bit(string name, logic got, logic exp);
        assert (got === exp) else begin
            report_fail($sformatf("ERROR: %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // one quiet cycle with noise on the request lines
    task automatic idle_cycle();
        @(negedge clk);
        req_op     = OP_NONE;
        req_addr   = random_addr();
        req_cached = (rand_below(2) == 1);
        #1;
        expect_bit("busy", busy, 1'b0);
        expect_bit("ins_valid", ins_valid, 1'b0);
    endtask

    task automatic index_invalidate(addr_t addr);
        int cnt0;
        cnt0 = req_count;
        @(negedge clk);
        req_op     = OP_INDEX_INV;
        req_addr   = addr;
        req_cached = (rand_below(2) == 1);
        stall      = 1'b0;
        #1;
        expect_bit("busy", busy, 1'b0);
        @(negedge clk);
        req_op = OP_NONE;
        #1;
        // single write cycle in the controller
        expect_bit("busy", busy, 1'b1);
        expect_bit("ins_valid", ins_valid, 1'b0);
        @(negedge clk);
        #1;
        expect_bit("busy", busy, 1'b0);
        expect_word("mem request count", req_count - cnt0, 0);
        model_valid[addr[10:5]] = 1'b0;
    endtask

    task automatic run_fetch(addr_t addr, logic cached, int stall_cycles);
        int          cnt0;
        int          lat;
        logic [5:0]  idx;
        logic [20:0] tag;
        logic        exp_hit;
        word_t       held;
        idx     = addr[10:5];
        tag     = addr[31:11];
        exp_hit = cached && model_valid[idx] && (model_tag[idx] == tag);
        cnt0    = req_count;
        @(negedge clk);
        req_op     = OP_FETCH;
        req_addr   = addr;
        req_cached = cached;
        stall      = 1'b0;
        #1;
        expect_bit("busy", busy, 1'b0);
        lat = 0;
        // wait for the answer, watchdog covers a hang
        do begin
            @(negedge clk);
            lat++;
            req_op     = OP_NONE;
            req_addr   = random_addr();
            req_cached = (rand_below(2) == 1);
            stall      = (stall_cycles > 0);
            #1;
        end while (!ins_valid);
        expect_word("ins", ins, expected_word(addr));
        expect_bit("busy", busy, stall_cycles > 0);
        if (cached) begin
            expect_bit("hit on first lookup", lat == 1, exp_hit);
        end
        held = ins;
        // answer must hold while stalled
        for (int i = 1; i < stall_cycles; i++) begin
            @(negedge clk);
            #1;
            expect_bit("ins_valid", ins_valid, 1'b1);
            expect_word("ins", ins, held);
            expect_bit("busy", busy, 1'b1);
        end
        if (stall_cycles > 0) begin
            @(negedge clk);
            stall = 1'b0;
            #1;
            expect_bit("ins_valid", ins_valid, 1'b1);
            expect_word("ins", ins, held);
            expect_bit("busy", busy, 1'b0);
        end
        expect_bit("mem_req_valid", mem_req_valid, 1'b0);
        if (exp_hit) begin
            expect_word("mem request count", req_count - cnt0, 0);
        end else begin
            expect_word("mem request count", req_count - cnt0, 1);
            expect_bit("mem_req.block", last_req.block, cached);
            if (cached) begin
                expect_word("mem_req.addr", last_req.addr, {addr[31:5], 5'b0});
                model_valid[idx] = 1'b1;
                model_tag[idx]   = tag;
            end else begin
                expect_word("mem_req.addr", last_req.addr, {addr[31:2], 2'b00});
            end
        end
    endtask

    initial begin
        int kind;
        int stall_n;
        seed       = SEED_INIT;
        rstn       = 1'b0;
        req_op     = OP_NONE;
        req_addr   = '0;
        req_cached = 1'b0;
        stall      = 1'b0;
        for (int s = 0; s < SETS; s++) begin
            model_valid[s] = 1'b0;
            model_tag[s]   = '0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        #1;
        expect_bit("busy", busy, 1'b0);
        expect_bit("ins_valid", ins_valid, 1'b0);
        expect_bit("mem_req_valid", mem_req_valid, 1'b0);
        for (int n = 0; n < N_TRANS; n++) begin
            kind    = rand_below(8);
            stall_n = (rand_below(3) == 0) ? 1 + rand_below(4) : 0;
            if (rand_below(4) == 0) begin
                idle_cycle();
            end
            // mostly cached fetches, some uncached, few invalidates
            if (kind == 0) begin
                index_invalidate(random_addr());
            end else begin
                run_fetch(random_addr(), kind != 1, stall_n);
            end
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

    // 400 cycles per transaction plus reset
    initial begin
        repeat ((N_TRANS + 2) * 400) @(posedge clk);
        report_fail("watchdog expired, the cache stopped answering requests");
    end

endmodule

`default_nettype wire

// File: tb_mem_responder.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mem_responder import icache_pkg::*; #(
    parameter int SEED = 1
) (
    input  wire logic     clk,
    input  wire logic     rstn,
    input  wire logic     mem_req_valid,
    input  wire mem_req_t mem_req,
    output logic          mem_req_ready,
    output logic          mem_done,
    output block_t        mem_rdata,
    output int            req_count,
    output mem_req_t      last_req
);

    int   seed;
    int   delay;
    logic pending;

    // memory contents, a fixed function of the word address
    function automatic word_t mem_word(addr_t byte_addr);
        return ((byte_addr >> 2) * 32'h9e37_79b1) ^ 32'ha5c3_3c5a;
    endfunction

    initial begin
        seed          = SEED;
        mem_req_ready = 1'b0;
        mem_done      = 1'b0;
        mem_rdata     = '0;
        pending       = 1'b0;
    end

    // all outputs change on the falling edge
    always @(negedge clk) begin
        if (!rstn) begin
            mem_req_ready <= 1'b0;
            mem_done      <= 1'b0;
            mem_rdata     <= '0;
            pending       <= 1'b0;
            delay         <= 0;
            req_count     <= 0;
            last_req      <= '0;
        end else begin
            mem_req_ready <= 1'b0;
            mem_done      <= 1'b0;
            if (pending) begin
                if (delay == 0) begin
                    mem_done <= 1'b1;
                    pending  <= 1'b0;
                    // word request only fills lane 0, the rest is noise
                    for (int i = 0; i < LINE_WORDS; i++) begin
                        if (last_req.block || (i == 0)) begin
                            mem_rdata[i*32 +: 32] <= mem_word(last_req.addr + 32'(4 * i));
                        end else begin
                            mem_rdata[i*32 +: 32] <= $random(seed);
                        end
                    end
                end else begin
                    delay <= delay - 1;
                end
            end else if (mem_req_valid && (($random(seed) & 3) != 0)) begin
                // valid is held, so the handshake lands on the next rising edge
                mem_req_ready <= 1'b1;
                pending       <= 1'b1;
                delay         <= $random(seed) & 7;
                req_count     <= req_count + 1;
                last_req      <= mem_req;
            end
        end
    end

endmodule

`default_nettype wire
